/* source/fft_settings.svh */
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// Transform geometry
`define FFT_POINTS  16
`define FFT_LOG2    4
`define FFT_IN_W    16
`define FFT_DATA_W  24
`define FFT_TW_FRAC 14

// APB register map in byte offsets
`define APB_ADDR_W  8
`define REG_CTRL    8'h00
`define REG_STATUS  8'h04
`define REG_IN_BASE 8'h40
`define REG_RE_BASE 8'h80
`define REG_IM_BASE 8'hC0

`endif

/* source/fft_pkg.sv */
`include "fft_settings.svh"

package fft_pkg;

    typedef logic signed [`FFT_DATA_W-1:0] sample_t;
    typedef logic signed [`FFT_IN_W-1:0]   in_part_t;
    typedef logic [`FFT_LOG2-1:0]          addr_t;
    typedef logic [`FFT_LOG2-2:0]          tw_idx_t;   // Twiddle index m from 0 to 7
    typedef logic [$clog2(`FFT_LOG2)-1:0]  stage_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef struct packed {
        logic    valid;
        addr_t   addr_a;
        addr_t   addr_b;
        tw_idx_t tw_idx;
    } bfly_rd_t;

    typedef struct packed {
        logic  valid;
        addr_t addr_a;
        addr_t addr_b;
        cplx_t a;
        cplx_t b;
    } bfly_wr_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        cplx_t data;
    } host_req_t;

    typedef enum logic [2:0] {IDLE, RUN, DRAIN, NEXT, DONE} fsm_state_t;

endpackage

/* source/fft_apb_regs.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft_apb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`APB_ADDR_W-1:0]  paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output fft_pkg::host_req_t      host_req_o,
    input  fft_pkg::cplx_t          host_rdata_i,
    output logic                    start_o,
    input  logic                    busy_i,
    input  logic                    done_i
);

    logic                   access;
    logic [`APB_ADDR_W-1:0] region;
    logic                   aligned;
    logic                   ctrl_hit;
    logic                   status_hit;
    logic                   in_hit;
    logic                   re_hit;
    logic                   im_hit;
    logic                   mapped;
    logic                   err;
    logic                   sample_rd;
    logic                   rd_wait_q;
    fft_pkg::addr_t         idx;
    fft_pkg::in_part_t      in_re;
    fft_pkg::in_part_t      in_im;
    fft_pkg::sample_t       rd_re;
    fft_pkg::sample_t       rd_im;

    assign access  = psel_i & penable_i;
    assign region  = paddr_i & {2'b11, {(`APB_ADDR_W-2){1'b0}}};   // Top two bits select the bank
    assign aligned = paddr_i[1:0] == 2'b00;
    assign idx     = paddr_i[5:2];

    assign ctrl_hit   = paddr_i == `REG_CTRL;
    assign status_hit = paddr_i == `REG_STATUS;
    assign in_hit     = aligned & (region == `REG_IN_BASE);
    assign re_hit     = aligned & (region == `REG_RE_BASE);
    assign im_hit     = aligned & (region == `REG_IM_BASE);

    // Inputs are write only and results read only
    assign mapped = ctrl_hit | status_hit | (in_hit & pwrite_i) | ((re_hit | im_hit) & ~pwrite_i);
    assign err    = access & (~mapped | ((in_hit | re_hit | im_hit) & busy_i));

    assign sample_rd = access & ~pwrite_i & (re_hit | im_hit) & ~busy_i;

    // First access cycle of a sample read fetches the word, second one returns it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= sample_rd & ~rd_wait_q;
        end
    end

    assign pready_o  = ~(sample_rd & ~rd_wait_q);
    assign pslverr_o = err;
    assign start_o   = access & pwrite_i & ctrl_hit & pwdata_i[0];

    assign in_re = pwdata_i[`FFT_IN_W-1:0];
    assign in_im = pwdata_i[2*`FFT_IN_W-1:`FFT_IN_W];

    always_comb begin
        host_req_o.rd      = sample_rd & ~rd_wait_q;
        host_req_o.wr      = access & pwrite_i & in_hit & ~busy_i;
        host_req_o.addr    = pwrite_i ? {idx[0], idx[1], idx[2], idx[3]} : idx;   // Bit-reversed load
        host_req_o.data.re = fft_pkg::sample_t'(in_re);
        host_req_o.data.im = fft_pkg::sample_t'(in_im);
    end

    assign rd_re = host_rdata_i.re;
    assign rd_im = host_rdata_i.im;

    always_comb begin
        prdata_o = '0;
        if (access & ~pwrite_i & ~err) begin
            if (status_hit) begin
                prdata_o = {30'd0, done_i, busy_i};
            end else if (re_hit) begin
                prdata_o = 32'(rd_re);
            end else if (im_hit) begin
                prdata_o = 32'(rd_im);
            end
        end
    end

endmodule

/* source/fft_ctrl_fsm.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft_ctrl_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  logic            stage_last_i,
    output logic            step_o,
    output fft_pkg::stage_t stage_o,
    output logic            busy_o,
    output logic            done_o
);

    fft_pkg::fsm_state_t state_q;
    fft_pkg::stage_t     stage_q;
    logic                drain_q;
    logic                last_stage;

    assign last_stage = stage_q == fft_pkg::stage_t'(`FFT_LOG2 - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fft_pkg::IDLE;
            stage_q <= '0;
            drain_q <= 1'b0;
        end else begin
            case (state_q)
                fft_pkg::IDLE, fft_pkg::DONE: begin
                    if (start_i) begin
                        state_q <= fft_pkg::RUN;
                        stage_q <= '0;
                    end
                end
                fft_pkg::RUN: begin
                    if (stage_last_i) begin
                        state_q <= fft_pkg::DRAIN;
                        drain_q <= 1'b0;
                    end
                end
                fft_pkg::DRAIN: begin
                    drain_q <= ~drain_q;
                    if (drain_q) state_q <= fft_pkg::NEXT;   // Two gap cycles let the pipeline empty
                end
                fft_pkg::NEXT: begin
                    if (last_stage) begin
                        state_q <= fft_pkg::DONE;
                        stage_q <= '0;
                    end else begin
                        state_q <= fft_pkg::RUN;
                        stage_q <= stage_q + fft_pkg::stage_t'(1);
                    end
                end
                default: state_q <= fft_pkg::IDLE;
            endcase
        end
    end

    // NEXT already issues the first butterfly of the following stage
    assign step_o  = (state_q == fft_pkg::RUN) | ((state_q == fft_pkg::NEXT) & ~last_stage);
    assign stage_o = (state_q == fft_pkg::NEXT) ? stage_q + fft_pkg::stage_t'(1) : stage_q;
    assign busy_o  = state_q inside {fft_pkg::RUN, fft_pkg::DRAIN, fft_pkg::NEXT};
    assign done_o  = state_q == fft_pkg::DONE;

endmodule

/* source/fft_addr_gen.sv */
`timescale 1ns/10ps

module fft_addr_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step_i,
    input  fft_pkg::stage_t    stage_i,
    output fft_pkg::bfly_rd_t  rd_o,
    output logic               stage_last_o
);

    logic [2:0]     cnt_q;     // Butterfly j within the stage
    fft_pkg::addr_t half;
    fft_pkg::addr_t k;
    fft_pkg::addr_t grp;
    fft_pkg::addr_t addr_a;
    fft_pkg::addr_t tw_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 3'd1;   // Wraps after butterfly 7
        end
    end

    always_comb begin
        half    = fft_pkg::addr_t'(1) << stage_i;
        k       = {1'b0, cnt_q} & (half - fft_pkg::addr_t'(1));
        grp     = {1'b0, cnt_q} >> stage_i;
        addr_a  = ((grp << stage_i) << 1) | k;
        tw_full = k << (2'd3 - stage_i);
    end

    always_comb begin
        rd_o.valid  = step_i;
        rd_o.addr_a = addr_a;
        rd_o.addr_b = addr_a + half;
        rd_o.tw_idx = tw_full[2:0];
    end

    assign stage_last_o = step_i & (cnt_q == 3'd7);

endmodule

/* source/fft_sample_ram.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft_sample_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  fft_pkg::host_req_t host_req_i,
    output fft_pkg::cplx_t     host_rdata_o,
    input  fft_pkg::bfly_rd_t  eng_rd_i,
    output fft_pkg::cplx_t     eng_a_o,
    output fft_pkg::cplx_t     eng_b_o,
    output fft_pkg::bfly_rd_t  eng_rd_o,
    input  fft_pkg::bfly_wr_t  eng_wr_i
);

    fft_pkg::cplx_t    mem_q [`FFT_POINTS];
    fft_pkg::cplx_t    eng_a_q;
    fft_pkg::cplx_t    eng_b_q;
    fft_pkg::cplx_t    host_rdata_q;
    fft_pkg::bfly_rd_t eng_rd_q;

    // Engine writes a result pair, otherwise the host may load one word
    always_ff @(posedge clk) begin
        if (eng_wr_i.valid) begin
            mem_q[eng_wr_i.addr_a] <= eng_wr_i.a;
            mem_q[eng_wr_i.addr_b] <= eng_wr_i.b;
        end else if (host_req_i.wr) begin
            mem_q[host_req_i.addr] <= host_req_i.data;
        end
    end

    always_ff @(posedge clk) begin
        eng_a_q <= mem_q[eng_rd_i.addr_a];
        eng_b_q <= mem_q[eng_rd_i.addr_b];
        if (host_req_i.rd) host_rdata_q <= mem_q[host_req_i.addr];
    end

    // Read request is delayed one cycle so it lines up with its operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eng_rd_q <= '0;
        end else begin
            eng_rd_q <= eng_rd_i;
        end
    end

    assign eng_a_o      = eng_a_q;
    assign eng_b_o      = eng_b_q;
    assign eng_rd_o     = eng_rd_q;
    assign host_rdata_o = host_rdata_q;

endmodule

/* source/fft_butterfly.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft_butterfly (
    input  logic              clk,
    input  logic              rst_n,
    input  fft_pkg::bfly_rd_t rd_i,
    input  fft_pkg::cplx_t    a_i,
    input  fft_pkg::cplx_t    b_i,
    output fft_pkg::bfly_wr_t wr_o
);

    logic signed [15:0] tw_re;
    logic signed [15:0] tw_im;
    fft_pkg::sample_t   a_re;
    fft_pkg::sample_t   a_im;
    fft_pkg::sample_t   b_re;
    fft_pkg::sample_t   b_im;
    logic signed [40:0] prod_re;
    logic signed [40:0] prod_im;
    fft_pkg::sample_t   wb_re;
    fft_pkg::sample_t   wb_im;
    logic               valid_q;
    fft_pkg::addr_t     addr_a_q;
    fft_pkg::addr_t     addr_b_q;
    fft_pkg::cplx_t     a_q;
    fft_pkg::cplx_t     b_q;

    // W^m in Q1.14 with -sin as the imaginary part
    always_comb begin
        case (rd_i.tw_idx)
            3'd0:    {tw_re, tw_im} = {16'sd16384, 16'sd0};
            3'd1:    {tw_re, tw_im} = {16'sd15137, -16'sd6270};
            3'd2:    {tw_re, tw_im} = {16'sd11585, -16'sd11585};
            3'd3:    {tw_re, tw_im} = {16'sd6270, -16'sd15137};
            3'd4:    {tw_re, tw_im} = {16'sd0, -16'sd16384};
            3'd5:    {tw_re, tw_im} = {-16'sd6270, -16'sd15137};
            3'd6:    {tw_re, tw_im} = {-16'sd11585, -16'sd11585};
            default: {tw_re, tw_im} = {-16'sd15137, -16'sd6270};
        endcase
    end

    assign a_re = a_i.re;
    assign a_im = a_i.im;
    assign b_re = b_i.re;
    assign b_im = b_i.im;

    // Products are summed at full width before the floor shift
    assign prod_re = b_re * tw_re - b_im * tw_im;
    assign prod_im = b_re * tw_im + b_im * tw_re;
    assign wb_re   = fft_pkg::sample_t'(prod_re >>> `FFT_TW_FRAC);
    assign wb_im   = fft_pkg::sample_t'(prod_im >>> `FFT_TW_FRAC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        addr_a_q <= rd_i.addr_a;
        addr_b_q <= rd_i.addr_b;
        a_q.re   <= a_re + wb_re;
        a_q.im   <= a_im + wb_im;
        b_q.re   <= a_re - wb_re;
        b_q.im   <= a_im - wb_im;
    end

    always_comb begin
        wr_o.valid  = valid_q;
        wr_o.addr_a = addr_a_q;
        wr_o.addr_b = addr_b_q;
        wr_o.a      = a_q;
        wr_o.b      = b_q;
    end

endmodule

/* source/fft16_top.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft16_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);

    fft_pkg::host_req_t host_req;
    fft_pkg::cplx_t     host_rdata;
    logic               start;
    logic               busy;
    logic               done;
    logic               step;
    logic               stage_last;
    fft_pkg::stage_t    stage;
    fft_pkg::bfly_rd_t  eng_rd;
    fft_pkg::bfly_rd_t  eng_rd_d;   // Aligned with the operands
    fft_pkg::cplx_t     eng_a;
    fft_pkg::cplx_t     eng_b;
    fft_pkg::bfly_wr_t  eng_wr;

    fft_apb_regs u_apb_regs (
        .clk, .rst_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .host_req_o(host_req), .host_rdata_i(host_rdata),
        .start_o(start), .busy_i(busy), .done_i(done)
    );

    fft_ctrl_fsm u_ctrl_fsm (
        .clk, .rst_n, .start_i(start), .stage_last_i(stage_last),
        .step_o(step), .stage_o(stage), .busy_o(busy), .done_o(done)
    );

    fft_addr_gen u_addr_gen (
        .clk, .rst_n, .step_i(step), .stage_i(stage),
        .rd_o(eng_rd), .stage_last_o(stage_last)
    );

    fft_sample_ram u_sample_ram (
        .clk, .rst_n, .host_req_i(host_req), .host_rdata_o(host_rdata),
        .eng_rd_i(eng_rd), .eng_a_o(eng_a), .eng_b_o(eng_b),
        .eng_rd_o(eng_rd_d), .eng_wr_i(eng_wr)
    );

    fft_butterfly u_butterfly (
        .clk, .rst_n, .rd_i(eng_rd_d), .a_i(eng_a), .b_i(eng_b), .wr_o(eng_wr)
    );

endmodule

/* tests/fft16_chk.sv */
`timescale 1ns/10ps

module fft16_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              pready_i,
    input logic              pslverr_i,
    input logic              busy_i,
    input logic              done_i,
    input fft_pkg::bfly_wr_t eng_wr_i
);

    int unsigned fail_cnt = 0;   // Number of failed assertions

    // An error response belongs to the completing cycle of a transfer
    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr_i |-> pready_i)
        else begin
            fail_cnt++;
            $error("pslverr_o is high while pready_o is low");
        end

    // Done never overlaps busy and only rises straight out of a busy cycle
    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> !busy_i && ($stable(done_i) || $past(busy_i)))
        else begin
            fail_cnt++;
            $error("done is high together with busy or rose without busy before it");
        end

    wr_addr_differ: assert property (@(posedge clk) disable iff (!rst_n)
        eng_wr_i.valid |-> (eng_wr_i.addr_a != eng_wr_i.addr_b))
        else begin
            fail_cnt++;
            $error("Engine write pair targets one address twice");
        end

endmodule

bind fft16_top fft16_chk fft16_chk_inst (
    .clk, .rst_n, .pready_i(pready_o), .pslverr_i(pslverr_o),
    .busy_i(busy), .done_i(done), .eng_wr_i(eng_wr)
);

/* tests/fft16_tb.sv */
`timescale 1ns/10ps
`include "fft_settings.svh"

module fft16_tb;

    localparam int  CLK_HALF   = 50;
    localparam int  WAIT_LIMIT = 8;
    localparam int  POLL_LIMIT = 100;
    localparam int  NUM_RANDOM = 20;
    localparam int  RUN_CYCLES = 41;
    localparam real PI         = 3.14159265358979323846;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    int          vec_re [`FFT_POINTS];     // Input vector in natural order
    int          vec_im [`FFT_POINTS];
    longint      model_re [`FFT_POINTS];   // Expected sample memory by address
    longint      model_im [`FFT_POINTS];
    logic [31:0] rng_state = 32'h898e_e282;
    int          errors = 0;
    int          checks = 0;
    int          busy_cycles = 0;
    int          run_len = 0;
    logic        prev_busy = 1'b0;
    logic        prev_done = 1'b0;

    fft16_top fft16_top_inst (
        .clk, .rst_n, .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // The busy length of each run is taken in the cycle where done rises
    always @(negedge clk) begin
        if (fft16_top_inst.busy && !prev_busy) begin
            busy_cycles = 1;
        end else if (fft16_top_inst.busy) begin
            busy_cycles++;
        end
        if (fft16_top_inst.done && !prev_done) begin
            run_len = prev_busy ? busy_cycles : 0;   // Done has to take over from busy directly
        end
        prev_busy = fft16_top_inst.busy;
        prev_done = fft16_top_inst.done;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] next_part();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    function automatic int bit_reverse(input int n);
        int r;
        int i;
        r = 0;
        for (i = 0; i < `FFT_LOG2; i++) begin
            r = (r << 1) | ((n >> i) & 1);
        end
        return r;
    endfunction

    // Parts are 24-bit two's complement values
    function automatic longint wrap24(input longint v);
        longint t;
        t = v & 64'hFF_FFFF;
        if (t >= (64'sd1 <<< (`FFT_DATA_W - 1))) t = t - (64'sd1 <<< `FFT_DATA_W);
        return t;
    endfunction

    // Four in-place DIT stages on the model memory with Q1.14 twiddles and floor shifts
    function automatic void fft_reference();
        int     s;
        int     j;
        int     h;
        int     k;
        int     ia;
        int     ib;
        int     m;
        real    ang;
        longint wr;
        longint wi;
        longint prod_r;
        longint prod_i;
        longint tr;
        longint ti;
        longint ar;
        longint ai;
        for (s = 0; s < `FFT_LOG2; s++) begin
            h = 1 << s;
            for (j = 0; j < `FFT_POINTS / 2; j++) begin
                k      = j % h;
                ia     = (j / h) * 2 * h + k;
                ib     = ia + h;
                m      = k * ((`FFT_POINTS / 2) >> s);
                ang    = 2.0 * PI * m / `FFT_POINTS;
                wr     = longint'(real'(1 << `FFT_TW_FRAC) * $cos(ang));
                wi     = longint'(-real'(1 << `FFT_TW_FRAC) * $sin(ang));
                prod_r = model_re[ib] * wr - model_im[ib] * wi;
                prod_i = model_re[ib] * wi + model_im[ib] * wr;
                tr     = wrap24(prod_r >>> `FFT_TW_FRAC);
                ti     = wrap24(prod_i >>> `FFT_TW_FRAC);
                ar     = model_re[ia];
                ai     = model_im[ia];
                model_re[ia] = wrap24(ar + tr);
                model_im[ia] = wrap24(ai + ti);
                model_re[ib] = wrap24(ar - tr);
                model_im[ib] = wrap24(ai - ti);
            end
        end
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not finish in time", what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #1;
        while (!pready && waits < WAIT_LIMIT) begin
            waits++;
            @(negedge clk);
            #1;
        end
        if (!pready) begin
            stop_on_timeout("APB transfer");
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, data, rdata, err, waits);
        check_value($sformatf("pslverr_o write 0x%02h", addr), 32'(err), 32'(exp_err));
        check_value($sformatf("pready_o low cycles write 0x%02h", addr), 32'(waits), 32'd0);
    endtask

    task automatic reg_read(input logic [7:0] addr, input logic exp_err, input int exp_waits,
                            output logic [31:0] data);
        logic err;
        int   waits;
        apb_xfer(1'b0, addr, 32'd0, data, err, waits);
        check_value($sformatf("pslverr_o read 0x%02h", addr), 32'(err), 32'(exp_err));
        check_value($sformatf("pready_o low cycles read 0x%02h", addr), 32'(waits),
                    32'(exp_waits));
    endtask

    task automatic load_vector();
        int n;
        for (n = 0; n < `FFT_POINTS; n++) begin
            reg_write(`REG_IN_BASE + 8'(4 * n), {vec_im[n][15:0], vec_re[n][15:0]}, 1'b0);
            model_re[bit_reverse(n)] = vec_re[n];
            model_im[bit_reverse(n)] = vec_im[n];
        end
    endtask

    task automatic start_fft();
        logic [31:0] status;
        run_len = 0;
        reg_write(`REG_CTRL, 32'h1, 1'b0);
        reg_read(`REG_STATUS, 1'b0, 0, status);
        check_value("prdata_o STATUS after start", status, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT) begin
            reg_read(`REG_STATUS, 1'b0, 0, status);
            polls++;
        end
        if (!status[1]) begin
            stop_on_timeout("FFT run");
        end
        check_value("prdata_o STATUS at end", status, 32'h2);
        check_value("busy to done cycles", 32'(run_len), 32'(RUN_CYCLES));
    endtask

    task automatic check_results(input string tag);
        logic [31:0] data;
        int          n;
        for (n = 0; n < `FFT_POINTS; n++) begin
            reg_read(`REG_RE_BASE + 8'(4 * n), 1'b0, 1, data);
            check_value($sformatf("%s prdata_o re[%0d]", tag, n), data, 32'(model_re[n]));
            reg_read(`REG_IM_BASE + 8'(4 * n), 1'b0, 1, data);
            check_value($sformatf("%s prdata_o im[%0d]", tag, n), data, 32'(model_im[n]));
        end
    endtask

    initial begin
        logic [31:0] data;
        int          n;
        int          v;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        reg_read(`REG_STATUS, 1'b0, 0, data);
        check_value("prdata_o STATUS after reset", data, 32'h0);

        // Impulse gives a flat spectrum
        for (n = 0; n < `FFT_POINTS; n++) begin
            vec_re[n] = (n == 0) ? 1000 : 0;
            vec_im[n] = 0;
        end
        load_vector();
        start_fft();
        wait_done();
        for (n = 0; n < `FFT_POINTS; n++) begin
            model_re[n] = 1000;
            model_im[n] = 0;
        end
        check_results("impulse");

        for (v = 0; v < NUM_RANDOM; v++) begin
            for (n = 0; n < `FFT_POINTS; n++) begin
                vec_re[n] = int'($signed(next_part()));
                vec_im[n] = int'($signed(next_part()));
            end
            load_vector();
            start_fft();
            wait_done();
            fft_reference();
            check_results($sformatf("random %0d", v));
        end

        // Memory now holds results in natural order, the engine transforms them again
        start_fft();
        wait_done();
        fft_reference();
        check_results("second pass");

        for (n = 0; n < `FFT_POINTS; n++) begin
            vec_re[n] = int'($signed(next_part()));
            vec_im[n] = int'($signed(next_part()));
        end
        load_vector();
        start_fft();
        reg_write(`REG_IN_BASE + 8'h08, 32'h1234_5678, 1'b1);   // Sample write while busy
        reg_read(8'h10, 1'b1, 0, data);
        reg_write(`REG_RE_BASE + 8'h04, 32'h5555_aaaa, 1'b1);
        wait_done();
        reg_read(`REG_IN_BASE, 1'b1, 0, data);
        reg_write(`REG_IM_BASE, 32'h0bad_cafe, 1'b1);
        reg_read(8'h3c, 1'b1, 0, data);
        fft_reference();
        check_results("after errors");

        errors += int'(fft16_top_inst.fft16_chk_inst.fail_cnt);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* fft16.f */
+incdir+source
source/fft_pkg.sv
source/fft_apb_regs.sv
source/fft_ctrl_fsm.sv
source/fft_addr_gen.sv
source/fft_sample_ram.sv
source/fft_butterfly.sv
source/fft16_top.sv
tests/fft16_chk.sv
tests/fft16_tb.sv

/* Bender.yml */
package:
  name: fft16

sources:
  - include_dirs:
      - source
    files:
      - source/fft_pkg.sv
      - source/fft_apb_regs.sv
      - source/fft_ctrl_fsm.sv
      - source/fft_addr_gen.sv
      - source/fft_sample_ram.sv
      - source/fft_butterfly.sv
      - source/fft16_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/fft16_chk.sv
      - tests/fft16_tb.sv
